// ==== common/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath word width.
`define XLEN 32

// Top bit set means the uop has no destination register.
`define TAG_W 7

// Cycles from acceptance to multiplier writeback.
`define MUL_LAT 3

// Restoring divider iterations, one quotient bit each.
`define DIV_STEPS 32

`endif

// ==== common/resultPkg.sv ====
`include "exec_consts.svh"

package resultPkg;

// Writeback tag, the low bits index the physical register.
typedef logic [`TAG_W-1:0] Tag;

// Physical register index.
typedef logic [`TAG_W-2:0] RegIdx;

// Result and operand word.
typedef logic [`XLEN-1:0] Word;

endpackage

// ==== common/uopPkg.sv ====
package uopPkg;

typedef enum logic [1:0] {
    FU_INT,
    FU_MUL,
    FU_DIV
} FuType;

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
} AluFunc;

typedef struct packed {
    AluFunc func;
    logic useImm;
    logic signed [10:0] imm;
} AluOp;

typedef enum logic [1:0] {MUL_LO, MUL_HI, MUL_HIU, MUL_HISU} MulFunc;
typedef enum logic [1:0] {DIV_QUOT, DIV_QUOTU, DIV_REM, DIV_REMU} DivFunc;

// isSigned marks operand A as signed: set for mulh, mulhsu, div and rem.
typedef struct packed {
    logic [1:0] func;
    logic isSigned;
    logic [12:0] pad;
} MulDivOp;

// Same word, read as AluOp by the ALU and as MulDivOp by mul/div.
typedef union packed {
    AluOp alu;
    MulDivOp md;
} OpWord;

typedef struct packed {
    logic valid;
    FuType fu;
    OpWord op;
    resultPkg::Tag tagDst;
    resultPkg::Word srcA;
    resultPkg::Word srcB;
} ExecUOp;

endpackage

// ==== design/RegFile.sv ====
`include "exec_consts.svh"

module RegFile
(
    input logic clk,
    input logic rstN,

    input resultPkg::RegIdx readAddrA,
    input resultPkg::RegIdx readAddrB,
    output resultPkg::Word readDataA,
    output resultPkg::Word readDataB,

    input logic writeEn,
    input resultPkg::RegIdx writeAddr,
    input resultPkg::Word writeData
);

import resultPkg::*;

Word regs[2**(`TAG_W-1)];

always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
        for (int i = 0; i < 2**(`TAG_W-1); i++)
            regs[i] <= '0;
    end else if (writeEn) begin
        regs[writeAddr] <= writeData;
    end
end

// Same-cycle write is forwarded.
assign readDataA = (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
assign readDataB = (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// ==== design/IntAlu.sv ====
`include "exec_consts.svh"

module IntAlu
(
    input logic clk,
    input logic rstN,

    input uopPkg::ExecUOp uop,

    output logic outValid,
    output resultPkg::Tag outTag,
    output resultPkg::Word outData
);

import uopPkg::*;
import resultPkg::*;

AluOp op;
Word opB;
Word result;
logic [$clog2(`XLEN)-1:0] shamt;

assign op = uop.op.alu;
assign opB = op.useImm ? {{(`XLEN-11){op.imm[10]}}, op.imm} : uop.srcB;
assign shamt = opB[$clog2(`XLEN)-1:0];

always_comb begin
    case (op.func)
        ALU_ADD: result = uop.srcA + opB;
        ALU_SUB: result = uop.srcA - opB;
        ALU_AND: result = uop.srcA & opB;
        ALU_OR: result = uop.srcA | opB;
        ALU_XOR: result = uop.srcA ^ opB;
        ALU_SLL: result = uop.srcA << shamt;
        ALU_SRL: result = uop.srcA >> shamt;
        ALU_SRA: result = $signed(uop.srcA) >>> shamt;
        ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(uop.srcA) < $signed(opB)};
        ALU_SLTU: result = {{(`XLEN-1){1'b0}}, uop.srcA < opB};
        default: result = '0;
    endcase
end

always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
        outValid <= 1'b0;
    else
        outValid <= uop.valid;
end

always_ff @(posedge clk) begin
    if (uop.valid) begin
        outTag <= uop.tagDst;
        outData <= result;
    end
end

endmodule

// ==== muldiv/Multiply.sv ====
`include "exec_consts.svh"

module Multiply
(
    input logic clk,
    input logic rstN,

    input uopPkg::ExecUOp uop,

    output logic outValid,
    output resultPkg::Tag outTag,
    output resultPkg::Word outData
);

import uopPkg::*;
import resultPkg::*;

MulDivOp op;
logic signA, signB;

logic s1Valid, s1High;
Tag s1Tag;
logic signed [`XLEN:0] s1A, s1B;

logic s2Valid, s2High;
Tag s2Tag;
logic signed [2*`XLEN+1:0] s2Prod;

assign op = uop.op.md;
// mulhsu keeps B unsigned.
assign signA = op.isSigned;
assign signB = op.isSigned && MulFunc'(op.func) != MUL_HISU;

always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
        s1Valid <= 1'b0;
        s2Valid <= 1'b0;
        outValid <= 1'b0;
    end else begin
        s1Valid <= uop.valid;
        s2Valid <= s1Valid;
        outValid <= s2Valid;
    end
end

always_ff @(posedge clk) begin
    s1A <= {signA && uop.srcA[`XLEN-1], uop.srcA};
    s1B <= {signB && uop.srcB[`XLEN-1], uop.srcB};
    s1High <= MulFunc'(op.func) != MUL_LO;
    s1Tag <= uop.tagDst;

    s2Prod <= s1A * s1B;
    s2High <= s1High;
    s2Tag <= s1Tag;

    outTag <= s2Tag;
    outData <= s2High ? s2Prod[2*`XLEN-1:`XLEN] : s2Prod[`XLEN-1:0];
end

endmodule

// ==== muldiv/Divide.sv ====
`include "exec_consts.svh"

module Divide
(
    input logic clk,
    input logic rstN,

    input uopPkg::ExecUOp uop,
    input logic wbFree,
    output logic busy,

    output logic outValid,
    output resultPkg::Tag outTag,
    output resultPkg::Word outData
);

import uopPkg::*;
import resultPkg::*;

localparam int stepW = $clog2(`DIV_STEPS + 1);

MulDivOp op;
logic signedOp;
Word dividendAbs, divisorAbs;

logic running, holding;
logic [stepW-1:0] stepsLeft;
logic [`XLEN:0] remAcc, shifted, diff;
Word quotAcc, divisor;
logic isRem, negQuot, negRem;

assign op = uop.op.md;
assign signedOp = op.isSigned;
assign dividendAbs = (signedOp && uop.srcA[`XLEN-1]) ? -uop.srcA : uop.srcA;
assign divisorAbs = (signedOp && uop.srcB[`XLEN-1]) ? -uop.srcB : uop.srcB;

// One restoring step per cycle.
assign shifted = {remAcc[`XLEN-1:0], quotAcc[`XLEN-1]};
assign diff = shifted - {1'b0, divisor};

assign busy = running || holding;
assign outValid = holding && wbFree;
assign outData = isRem ? (negRem ? -remAcc[`XLEN-1:0] : remAcc[`XLEN-1:0])
                       : (negQuot ? -quotAcc : quotAcc);

always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
        running <= 1'b0;
        holding <= 1'b0;
        stepsLeft <= '0;
    end else if (uop.valid) begin
        running <= 1'b1;
        stepsLeft <= stepW'(`DIV_STEPS);
    end else if (running) begin
        stepsLeft <= stepsLeft - 1'b1;
        if (stepsLeft == stepW'(1)) begin
            running <= 1'b0;
            holding <= 1'b1;
        end
    end else if (outValid) begin
        holding <= 1'b0;
    end
end

// Divide by zero keeps an all ones quotient, so no sign fix there.
always_ff @(posedge clk) begin
    if (uop.valid) begin
        remAcc <= '0;
        quotAcc <= dividendAbs;
        divisor <= divisorAbs;
        isRem <= DivFunc'(op.func) inside {DIV_REM, DIV_REMU};
        negQuot <= signedOp && (uop.srcA[`XLEN-1] ^ uop.srcB[`XLEN-1]) && uop.srcB != '0;
        negRem <= signedOp && uop.srcA[`XLEN-1];
        outTag <= uop.tagDst;
    end else if (running) begin
        if (!diff[`XLEN]) begin
            remAcc <= diff;
            quotAcc <= {quotAcc[`XLEN-2:0], 1'b1};
        end else begin
            remAcc <= shifted;
            quotAcc <= {quotAcc[`XLEN-2:0], 1'b0};
        end
    end
end

endmodule

// ==== design/IssueControl.sv ====
`include "exec_consts.svh"

module IssueControl
(
    input logic clk,
    input logic rstN,

    input logic inValid,
    input uopPkg::FuType inFu,
    input uopPkg::OpWord inOp,
    input resultPkg::Tag inTagDst,
    input resultPkg::RegIdx inSrcA,
    input resultPkg::RegIdx inSrcB,
    input logic inUseSrcB,
    output logic inReady,

    output logic resValid,
    output resultPkg::Tag resTag,
    output resultPkg::Word resData,

    output resultPkg::RegIdx rfReadAddrA,
    output resultPkg::RegIdx rfReadAddrB,
    input resultPkg::Word rfReadDataA,
    input resultPkg::Word rfReadDataB,
    output logic rfWriteEn,
    output resultPkg::RegIdx rfWriteAddr,
    output resultPkg::Word rfWriteData,

    output uopPkg::ExecUOp aluUOp,
    output uopPkg::ExecUOp mulUOp,
    output uopPkg::ExecUOp divUOp,

    input logic aluValid,
    input resultPkg::Tag aluTag,
    input resultPkg::Word aluData,
    input logic mulValid,
    input resultPkg::Tag mulTag,
    input resultPkg::Word mulData,
    input logic divValid,
    input resultPkg::Tag divTag,
    input resultPkg::Word divData,
    input logic divBusy,
    output logic divWbFree
);

import uopPkg::*;

// Bit d set means the slot after the d-th next edge belongs to a MUL.
logic [`MUL_LAT-1:1] slotBooked;
logic accept;
ExecUOp issued;

assign rfReadAddrA = inSrcA;
assign rfReadAddrB = inSrcB;

// The MUL slot itself is never booked with a single issue port.
always_comb begin
    inReady = 1'b1;
    if (inFu == FU_INT && slotBooked[1])
        inReady = 1'b0;
    if (inFu == FU_DIV && divBusy)
        inReady = 1'b0;
end

assign accept = inValid && inReady;

always_comb begin
    issued.valid = accept;
    issued.fu = inFu;
    issued.op = inOp;
    issued.tagDst = inTagDst;
    issued.srcA = rfReadDataA;
    // Without a register B the ALU uses its immediate.
    issued.srcB = inUseSrcB ? rfReadDataB : '0;
end

always_comb begin
    aluUOp = issued;
    mulUOp = issued;
    divUOp = issued;
    aluUOp.valid = accept && inFu == FU_INT;
    mulUOp.valid = accept && inFu == FU_MUL;
    divUOp.valid = accept && inFu == FU_DIV;
end

always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
        slotBooked <= '0;
    else
        slotBooked <= {accept && inFu == FU_MUL, slotBooked[`MUL_LAT-1:2]};
end

// Divider takes any slot left empty by ALU and MUL.
assign divWbFree = !aluValid && !mulValid;

always_comb begin
    resValid = aluValid || mulValid || divValid;
    if (aluValid) begin
        resTag = aluTag;
        resData = aluData;
    end else if (mulValid) begin
        resTag = mulTag;
        resData = mulData;
    end else begin
        resTag = divTag;
        resData = divData;
    end
end

assign rfWriteEn = resValid && !resTag[`TAG_W-1];
assign rfWriteAddr = resTag[`TAG_W-2:0];
assign rfWriteData = resData;

endmodule

// ==== design/ExecCluster.sv ====
module ExecCluster
(
    input logic clk,
    input logic rstN,

    input logic inValid,
    input uopPkg::FuType inFu,
    input uopPkg::OpWord inOp,
    input resultPkg::Tag inTagDst,
    input resultPkg::RegIdx inSrcA,
    input resultPkg::RegIdx inSrcB,
    input logic inUseSrcB,
    output logic inReady,

    output logic resValid,
    output resultPkg::Tag resTag,
    output resultPkg::Word resData
);

resultPkg::RegIdx rfReadAddrA, rfReadAddrB, rfWriteAddr;
resultPkg::Word rfReadDataA, rfReadDataB, rfWriteData;
logic rfWriteEn;

uopPkg::ExecUOp aluUOp, mulUOp, divUOp;

logic aluValid, mulValid, divValid;
resultPkg::Tag aluTag, mulTag, divTag;
resultPkg::Word aluData, mulData, divData;
logic divBusy, divWbFree;

// Port names match the wires above.
IssueControl issueCtrl (.*);

RegFile rf
(
    .clk(clk),
    .rstN(rstN),
    .readAddrA(rfReadAddrA),
    .readAddrB(rfReadAddrB),
    .readDataA(rfReadDataA),
    .readDataB(rfReadDataB),
    .writeEn(rfWriteEn),
    .writeAddr(rfWriteAddr),
    .writeData(rfWriteData)
);

IntAlu alu
(
    .clk(clk),
    .rstN(rstN),
    .uop(aluUOp),
    .outValid(aluValid),
    .outTag(aluTag),
    .outData(aluData)
);

Multiply mul
(
    .clk(clk),
    .rstN(rstN),
    .uop(mulUOp),
    .outValid(mulValid),
    .outTag(mulTag),
    .outData(mulData)
);

Divide div
(
    .clk(clk),
    .rstN(rstN),
    .uop(divUOp),
    .wbFree(divWbFree),
    .busy(divBusy),
    .outValid(divValid),
    .outTag(divTag),
    .outData(divData)
);

endmodule

// ==== tb/execCluster_chk.sv ====
module execClusterChk
(
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic inReady,
    input uopPkg::FuType inFu,
    input resultPkg::Tag inTagDst,
    input logic resValid,
    input resultPkg::Tag resTag,
    input logic aluValid,
    input logic mulValid,
    input logic divValid
);

timeunit 1ns;
timeprecision 1ps;

import uopPkg::*;

int failures = 0;
logic acceptDiv;
logic divOpen;

assign acceptDiv = inValid && inReady && inFu == FU_DIV;

// A divide stays open from acceptance until its writeback.
always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
        divOpen <= 1'b0;
    else if (acceptDiv)
        divOpen <= 1'b1;
    else if (divValid)
        divOpen <= 1'b0;
end

divWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
    acceptDiv |-> !divOpen)
    else begin
        $error("DIV uop accepted while the divider is busy");
        failures++;
    end

// Result register loads on the accepting edge and is seen on the next.
aluResultTiming: assert property (@(posedge clk) disable iff (!rstN)
    (inValid && inReady && inFu == FU_INT) |-> ##1 (resValid && resTag == $past(inTagDst)))
    else begin
        $error("ALU result tag did not appear one cycle after acceptance");
        failures++;
    end

oneWriteback: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({aluValid, mulValid, divValid}))
    else begin
        $error("More than one unit result taken in one cycle");
        failures++;
    end

endmodule

bind IssueControl execClusterChk chk (.*);

// ==== tb/execClusterTb.sv ====
`include "exec_consts.svh"

module execClusterTb;

timeunit 1ns;
timeprecision 1ps;

import uopPkg::*;
import resultPkg::*;

localparam int maxPats = 128;
localparam int never = 32'h7fffffff;

logic clk;
logic rstN;
logic inValid;
FuType inFu;
OpWord inOp;
Tag inTagDst;
RegIdx inSrcA;
RegIdx inSrcB;
logic inUseSrcB;
logic inReady;
logic resValid;
Tag resTag;
Word resData;

int pFu[maxPats], pFunc[maxPats], pFlag[maxPats], pImm[maxPats];
int pTag[maxPats], pA[maxPats], pB[maxPats];
Word pExp[maxPats];
int numPats = 0;

logic pending[128];
Word expVal[128];
int expFu[128];
int acceptAt[128];
int readyAt[64];
int pendingCount = 0;
int cycle = 0;
int mismatches = 0;
int otherErrors = 0;

ExecCluster i_ExecCluster (.*);

always #4 clk = ~clk;

task automatic loadPatterns();
    int fd;
    int cnt;
    string line;
    int fuV, funcV, flagV, immV, tagV, aV, bV;
    Word expV;
    fd = $fopen("tb/exec_patterns.txt", "r");
    if (fd == 0) begin
        $display("Could not open the pattern file tb/exec_patterns.txt");
        otherErrors++;
        return;
    end
    while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
            cnt = $sscanf(line, "%d %d %d %d %d %d %d %h",
                          fuV, funcV, flagV, immV, tagV, aV, bV, expV);
            if (cnt == 8 && numPats < maxPats) begin
                pFu[numPats] = fuV;
                pFunc[numPats] = funcV;
                pFlag[numPats] = flagV;
                pImm[numPats] = immV;
                pTag[numPats] = tagV;
                pA[numPats] = aV;
                pB[numPats] = bV;
                pExp[numPats] = expV;
                numPats++;
            end
        end
    end
    $fclose(fd);
endtask

// Immediate ALU ops take no register B.
function automatic logic usesSrcB(int k);
    return !(pFu[k] == 0 && pFlag[k] != 0);
endfunction

function automatic logic sourcesReady(int k);
    logic ok;
    ok = readyAt[pA[k] % 64] <= cycle + 1;
    if (usesSrcB(k))
        ok = ok && readyAt[pB[k] % 64] <= cycle + 1;
    return ok;
endfunction

task automatic driveUop(int k);
    OpWord w;
    w = '0;
    if (pFu[k] == 0) begin
        w.alu.func = AluFunc'(pFunc[k]);
        w.alu.useImm = pFlag[k][0];
        w.alu.imm = pImm[k][10:0];
    end else begin
        w.md.func = pFunc[k][1:0];
        w.md.isSigned = pFlag[k][0];
    end
    inValid <= 1'b1;
    inFu <= FuType'(pFu[k]);
    inOp <= w;
    inTagDst <= pTag[k][6:0];
    inSrcA <= pA[k][5:0];
    inSrcB <= pB[k][5:0];
    inUseSrcB <= usesSrcB(k);
endtask

task automatic recordAccept(int k);
    int t;
    t = pTag[k];
    assert (!pending[t]) else begin
        $display("Tag %0d was issued again while still in flight", t);
        otherErrors++;
    end
    pending[t] = 1'b1;
    pendingCount++;
    expVal[t] = pExp[k];
    expFu[t] = pFu[k];
    acceptAt[t] = cycle;
    // Earliest edge a dependent uop can be accepted, through the bypass.
    if (pFu[k] == 0)
        readyAt[t % 64] = cycle + 1;
    else if (pFu[k] == 1)
        readyAt[t % 64] = cycle + `MUL_LAT;
    else
        readyAt[t % 64] = never;
endtask

task automatic collectResult();
    int t;
    int lat;
    if (!resValid)
        return;
    t = resTag;
    assert (pending[t]) else begin
        $display("Duplicate or unexpected result for tag %0d at %0t", t, $time);
        otherErrors++;
        return;
    end
    pending[t] = 1'b0;
    pendingCount--;
    lat = cycle - acceptAt[t];
    assert (resData === expVal[t]) else begin
        $display("MISMATCH at %0t: tag %0d data %h, expected %h", $time, t, resData, expVal[t]);
        mismatches++;
    end
    if (expFu[t] == 0) begin
        assert (lat == 1) else begin
            $display("MISMATCH at %0t: ALU tag %0d latency %0d, expected 1", $time, t, lat);
            mismatches++;
        end
    end else if (expFu[t] == 1) begin
        assert (lat == `MUL_LAT) else begin
            $display("MISMATCH at %0t: MUL tag %0d latency %0d, expected %0d",
                     $time, t, lat, `MUL_LAT);
            mismatches++;
        end
    end else begin
        assert (lat >= `DIV_STEPS + 1) else begin
            $display("MISMATCH at %0t: DIV tag %0d latency %0d too short", $time, t, lat);
            mismatches++;
        end
        readyAt[t % 64] = cycle;
    end
endtask

initial begin
    int idx;
    int gap;
    logic driving;
    int assertFails;
    void'($urandom(32'h26b6d74e));
    clk = 1'b0;
    rstN = 1'b0;
    inValid = 1'b0;
    inFu = FU_INT;
    inOp = '0;
    inTagDst = '0;
    inSrcA = '0;
    inSrcB = '0;
    inUseSrcB = 1'b0;
    foreach (pending[i])
        pending[i] = 1'b0;
    foreach (readyAt[i])
        readyAt[i] = 0;
    loadPatterns();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    assert (!resValid && inReady) else begin
        $display("After reset resValid is not low or inReady is not high");
        otherErrors++;
    end
    idx = 0;
    gap = 0;
    driving = 1'b0;
    while (idx < numPats || pendingCount > 0) begin
        @(posedge clk);
        cycle++;
        collectResult();
        if (driving && inReady) begin
            recordAccept(idx);
            inValid <= 1'b0;
            driving = 1'b0;
            idx++;
            gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
        end
        if (!driving && idx < numPats) begin
            if (gap > 0)
                gap--;
            else if (sourcesReady(idx)) begin
                driveUop(idx);
                driving = 1'b1;
            end
        end
    end
    assertFails = i_ExecCluster.issueCtrl.chk.failures;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, otherErrors, assertFails);
    if (mismatches == 0 && otherErrors == 0 && assertFails == 0)
        $display("All tests passed!");
    else
        $display("Test failures found");
    $finish;
end

// Watchdog.
initial begin
    wait (rstN === 1'b1);
    repeat (numPats * (`DIV_STEPS + 8) + 50) @(posedge clk);
    $display("Timeout: run did not finish, %0d results still missing", pendingCount);
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, otherErrors + 1, i_ExecCluster.issueCtrl.chk.failures);
    $display("Test failures found");
    $finish;
end

endmodule

// ==== tb/exec_patterns.txt ====
# fu(0 alu,1 mul,2 div) func flag(useImm or signed) imm tag srcA srcB expected(hex)
# tags 64 and up carry no destination
0 0 0 0 1 20 21 00000000
0 0 1 100 2 0 0 00000064
0 0 1 -7 3 0 0 fffffff9
0 0 1 1 4 0 0 00000001
0 5 1 31 5 4 0 80000000
0 0 1 -1 6 0 0 ffffffff
0 0 1 1023 7 0 0 000003ff
0 5 1 10 8 7 0 000ffc00
0 1 0 0 9 2 3 0000006b
0 2 0 0 10 3 7 000003f9
0 3 0 0 11 8 2 000ffc64
0 4 0 0 12 3 6 00000006
0 5 0 0 13 7 4 000007fe
0 6 0 0 14 5 4 40000000
0 7 0 0 15 5 4 c0000000
0 8 0 0 16 3 2 00000001
0 9 0 0 17 3 2 00000000
0 8 1 -1 18 2 0 00000000
0 9 1 -1 19 2 0 00000001
0 4 1 -2 22 6 0 00000001
0 7 1 2 23 3 0 fffffffe
0 3 1 -1024 24 2 0 fffffc64
1 0 1 0 25 3 2 fffffd44
1 1 1 0 26 3 2 ffffffff
1 2 0 0 27 3 2 00000063
1 3 1 0 28 3 6 fffffff9
1 1 1 0 29 5 5 40000000
2 0 1 0 30 2 3 fffffff2
2 2 1 0 31 2 3 00000002
2 1 0 0 32 3 2 028f5c28
2 3 0 0 33 3 2 00000059
2 0 1 0 34 2 1 ffffffff
2 2 1 0 35 3 1 fffffff9
2 0 1 0 36 5 6 80000000
2 2 1 0 37 5 6 00000000
0 0 0 0 38 25 26 fffffd43
0 0 1 1 39 38 0 fffffd44
0 0 0 0 40 39 30 fffffd36
0 0 1 5 66 0 0 00000005
0 0 0 0 41 2 0 00000064
1 0 1 0 71 7 4 000003ff
0 0 1 0 42 7 0 000003ff

// ==== execCluster.f ====
+incdir+common
common/resultPkg.sv
common/uopPkg.sv
design/RegFile.sv
design/IntAlu.sv
muldiv/Multiply.sv
muldiv/Divide.sv
design/IssueControl.sv
design/ExecCluster.sv
tb/execCluster_chk.sv
tb/execClusterTb.sv
